/* design/fetch_cfg_pkg.sv */
// Fixed to 32-bit addresses and four-word blocks; derived widths are not recomputed elsewhere
`default_nettype none

package fetch_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Address and block geometry
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W         = 32;
    localparam int BLOCK_WORDS    = 4;
    localparam int SLOT_W         = 2;   // Selects a word in the block
    localparam int BLOCK_OFFSET_W = 4;   // Byte offset of a block

    // BTB sizing
    localparam int BTB_ENTRIES = 64;
    localparam int BTB_INDEX_W = 6;
    localparam int BTB_TAG_W   = ADDR_W - BTB_INDEX_W - BLOCK_OFFSET_W;

    localparam logic [ADDR_W-1:0] RESET_PC = 32'hBFC0_0000;   // MIPS boot vector

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [SLOT_W-1:0]      slot_t;
    typedef logic [BLOCK_WORDS-1:0] mask_t;

    // Slot 0 sits in the low word
    typedef logic [BLOCK_WORDS-1:0][31:0] block_data_t;

endpackage

`default_nettype wire

/* design/fetch_msg_pkg.sv */
// Messages between fetch stages; field order is fixed and shared with the testbench model
`default_nettype none

package fetch_msg_pkg;

    // BTB answer for the block at the lookup PC
    typedef struct packed {
        logic                 hit;
        fetch_cfg_pkg::slot_t slot;     // Slot of the predicted branch
        fetch_cfg_pkg::addr_t target;
    } btb_pred_t;

    // Single-cycle redirect from the back end
    typedef struct packed {
        logic                 br_valid;
        logic                 exc_valid;   // Wins over br_valid
        fetch_cfg_pkg::addr_t br_pc;
        fetch_cfg_pkg::addr_t br_target;
        logic                 br_taken;
        fetch_cfg_pkg::addr_t exc_pc;
    } redirect_t;

    ////////////////////////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////////////////////////

    // Accepted request waiting on the cache
    typedef struct packed {
        fetch_cfg_pkg::addr_t pc;      // Unaligned fetch PC
        fetch_cfg_pkg::mask_t mask;
        btb_pred_t            pred;
    } fetch_req_t;

    // Block handed to the instruction queue
    typedef struct packed {
        fetch_cfg_pkg::addr_t       base_pc;
        fetch_cfg_pkg::mask_t       mask;
        fetch_cfg_pkg::block_data_t data;
        logic                       pred_taken;
        fetch_cfg_pkg::addr_t       pred_target;
    } fetch_block_t;

endpackage

`default_nettype wire

/* design/fetch_trace_stage.sv */
// Single entry; a stale entry stays until advance_i, so the first stage keeps one answer per request
`timescale 1ns/1ps
`default_nettype none

module fetch_trace_stage #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst_n_i,
    input  wire           flush_i,
    input  wire           push_i,
    input  wire payload_t data_i,
    input  wire           advance_i,
    output logic          ready_o,
    output logic          out_valid_o,
    output payload_t      data_o
);

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_LIVE,
        ST_STALE     // Killed by a redirect, still occupying the slot
    } slot_state_e;

    slot_state_e state_q;
    payload_t    data_q;
    logic        load;

    assign ready_o     = (state_q == ST_EMPTY) | advance_i;
    assign load        = push_i & ready_o & ~flush_i;   // Push under flush is lost
    assign out_valid_o = (state_q == ST_LIVE);
    assign data_o      = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_EMPTY;
        end else if (load) begin
            state_q <= ST_LIVE;
        end else if (advance_i) begin
            state_q <= ST_EMPTY;
        end else if (flush_i && state_q == ST_LIVE) begin
            state_q <= ST_STALE;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    // Upstream and downstream agree on occupancy
    a_no_empty_advance: assert property (@(posedge clk) disable iff (!rst_n_i)
        advance_i |-> state_q != ST_EMPTY);

endmodule

`default_nettype wire

/* design/pc_register.sv */
// One request in flight; inst_req_o drops during a redirect cycle, so no accept meets a flush
`timescale 1ns/1ps
`default_nettype none

module pc_register (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire fetch_msg_pkg::redirect_t  redirect_i,
    input  wire fetch_msg_pkg::btb_pred_t  pred_i,
    input  wire                            slot_free_i,
    input  wire                            inst_index_ok_i,
    output fetch_cfg_pkg::addr_t           lookup_pc_o,
    output logic                           inst_req_o,
    output fetch_cfg_pkg::addr_t           inst_index_o,
    output fetch_msg_pkg::fetch_req_t      req_o,
    output logic                           push_o
);
    import fetch_cfg_pkg::*;
    import fetch_msg_pkg::*;

    addr_t pc_q;
    logic  run_q;        // Low through reset and its first cycle out
    logic  accept;
    logic  redir_any;
    addr_t redir_pc;
    addr_t seq_pc;
    slot_t first_slot;
    slot_t last_slot;
    mask_t en_mask;

    assign redir_any = redirect_i.br_valid | redirect_i.exc_valid;
    assign accept    = inst_req_o & inst_index_ok_i;
    assign seq_pc    = {pc_q[ADDR_W-1:BLOCK_OFFSET_W] + 1'b1, {BLOCK_OFFSET_W{1'b0}}};

    // Exception first, then resolved direction
    always_comb begin
        if (redirect_i.exc_valid) begin
            redir_pc = redirect_i.exc_pc;
        end else if (redirect_i.br_taken) begin
            redir_pc = redirect_i.br_target;
        end else begin
            redir_pc = redirect_i.br_pc + 32'd4;
        end
    end

    // Enable from the entry slot up to the predicted branch
    assign first_slot = pc_q[BLOCK_OFFSET_W-1 -: SLOT_W];
    assign last_slot  = pred_i.hit ? pred_i.slot : slot_t'(BLOCK_WORDS - 1);

    always_comb begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            en_mask[i] = (slot_t'(i) >= first_slot) && (slot_t'(i) <= last_slot);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redir_any) begin
                pc_q <= redir_pc;
            end else if (accept) begin
                pc_q <= pred_i.hit ? pred_i.target : seq_pc;
            end
        end
    end

    assign lookup_pc_o  = pc_q;
    assign inst_index_o = {pc_q[ADDR_W-1:BLOCK_OFFSET_W], {BLOCK_OFFSET_W{1'b0}}};
    assign inst_req_o   = run_q & slot_free_i & ~redir_any;
    assign push_o       = accept;
    assign req_o        = '{pc: pc_q, mask: en_mask, pred: pred_i};

    // Pending request holds with its index until the cache takes it
    a_index_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_req_o && !inst_index_ok_i && !redir_any
        |=> $stable(inst_index_o) && (inst_req_o || redir_any));

endmodule

`default_nettype wire

/* design/branch_target_buffer.sv */
// Direct mapped, one branch per block; every branch resolve trains, even one that meets an exception
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire fetch_cfg_pkg::addr_t      lookup_pc_i,
    input  wire fetch_msg_pkg::redirect_t  redirect_i,
    output fetch_msg_pkg::btb_pred_t       pred_o
);
    import fetch_cfg_pkg::*;
    import fetch_msg_pkg::*;

    typedef logic [BTB_INDEX_W-1:0] index_t;
    typedef logic [BTB_TAG_W-1:0]   tag_t;

    logic [BTB_ENTRIES-1:0] valid_q;
    tag_t                   tag_mem    [BTB_ENTRIES];
    slot_t                  slot_mem   [BTB_ENTRIES];
    addr_t                  target_mem [BTB_ENTRIES];

    index_t rd_idx;
    tag_t   rd_tag;
    slot_t  rd_slot;
    index_t wr_idx;
    tag_t   wr_tag;
    slot_t  wr_slot;
    logic   wr_match;

    ////////////////////////////////////////////////////////////
    // Lookup, same cycle
    ////////////////////////////////////////////////////////////
    assign rd_idx  = lookup_pc_i[BLOCK_OFFSET_W +: BTB_INDEX_W];   // Bits 9..4
    assign rd_tag  = lookup_pc_i[ADDR_W-1 -: BTB_TAG_W];
    assign rd_slot = lookup_pc_i[BLOCK_OFFSET_W-1 -: SLOT_W];

    // A branch behind the entry slot is never reached
    assign pred_o.hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag)
                        && (slot_mem[rd_idx] >= rd_slot);
    assign pred_o.slot   = slot_mem[rd_idx];
    assign pred_o.target = target_mem[rd_idx];

    ////////////////////////////////////////////////////////////
    // Training from branch resolve
    ////////////////////////////////////////////////////////////
    assign wr_idx   = redirect_i.br_pc[BLOCK_OFFSET_W +: BTB_INDEX_W];
    assign wr_tag   = redirect_i.br_pc[ADDR_W-1 -: BTB_TAG_W];
    assign wr_slot  = redirect_i.br_pc[BLOCK_OFFSET_W-1 -: SLOT_W];
    assign wr_match = valid_q[wr_idx] && (tag_mem[wr_idx] == wr_tag)
                      && (slot_mem[wr_idx] == wr_slot);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (redirect_i.br_valid) begin
            if (redirect_i.br_taken) begin
                valid_q[wr_idx] <= 1'b1;
            end else if (wr_match) begin
                valid_q[wr_idx] <= 1'b0;     // Only the same branch is dropped
            end
        end
    end

    // Entry fields
    always_ff @(posedge clk) begin
        if (redirect_i.br_valid && redirect_i.br_taken) begin
            tag_mem[wr_idx]    <= wr_tag;
            slot_mem[wr_idx]   <= wr_slot;
            target_mem[wr_idx] <= redirect_i.br_target;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_stage_top.sv */
// Cache must return data in order, one data_ok per accepted index; rdata is used only with data_ok
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_top (
    input  wire                               clk,
    input  wire                               rst_n_i,
    // Instruction cache
    output logic                              inst_req_o,
    output fetch_cfg_pkg::addr_t              inst_index_o,
    input  wire                               inst_index_ok_i,
    input  wire                               inst_data_ok_i,
    input  wire fetch_cfg_pkg::block_data_t   inst_rdata_i,
    // Back end and instruction queue
    input  wire fetch_msg_pkg::redirect_t     redirect_i,
    input  wire                               stop_fetch_i,
    output logic                              block_valid_o,
    output fetch_msg_pkg::fetch_block_t       block_o
);
    import fetch_cfg_pkg::*;
    import fetch_msg_pkg::*;

    addr_t        lookup_pc;
    btb_pred_t    pred;
    fetch_req_t   pc_req;
    logic         pc_push;
    logic         slot_free;
    logic         flush;

    logic         first_ready;
    logic         first_valid;
    fetch_req_t   first_req;

    fetch_block_t block_in;
    logic         block_push;
    logic         second_ready;
    logic         second_adv;
    logic         second_stale_q;   // Flushed block parked behind stop_fetch_i

    assign flush = redirect_i.br_valid | redirect_i.exc_valid;

    // Request only into an empty first slot with room behind it
    assign slot_free = first_ready & second_ready & ~inst_data_ok_i;

    ////////////////////////////////////////////////////////////
    // PC and prediction
    ////////////////////////////////////////////////////////////
    pc_register u_pc_register (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect_i),
        .pred_i          (pred),
        .slot_free_i     (slot_free),
        .inst_index_ok_i (inst_index_ok_i),
        .lookup_pc_o     (lookup_pc),
        .inst_req_o      (inst_req_o),
        .inst_index_o    (inst_index_o),
        .req_o           (pc_req),
        .push_o          (pc_push)
    );

    branch_target_buffer u_btb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lookup_pc_i (lookup_pc),
        .redirect_i  (redirect_i),
        .pred_o      (pred)
    );

    ////////////////////////////////////////////////////////////
    // Trace stages
    ////////////////////////////////////////////////////////////
    fetch_trace_stage #(.payload_t(fetch_req_t)) u_first_trace (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .push_i      (pc_push),
        .data_i      (pc_req),
        .advance_i   (inst_data_ok_i),   // Leaves with its cache answer
        .ready_o     (first_ready),
        .out_valid_o (first_valid),
        .data_o      (first_req)
    );

    always_comb begin
        block_in.base_pc     = {first_req.pc[ADDR_W-1:BLOCK_OFFSET_W], {BLOCK_OFFSET_W{1'b0}}};
        block_in.mask        = first_req.mask;
        block_in.data        = inst_rdata_i;
        block_in.pred_taken  = first_req.pred.hit;
        block_in.pred_target = first_req.pred.target;
    end

    assign block_push = inst_data_ok_i & first_valid;   // Stale answers are dropped here
    assign second_adv = ~stop_fetch_i & (block_valid_o | second_stale_q);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            second_stale_q <= 1'b0;
        end else if (second_adv) begin
            second_stale_q <= 1'b0;
        end else if (flush && block_valid_o) begin
            second_stale_q <= 1'b1;
        end
    end

    fetch_trace_stage #(.payload_t(fetch_block_t)) u_second_trace (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .push_i      (block_push),
        .data_i      (block_in),
        .advance_i   (second_adv),
        .ready_o     (second_ready),
        .out_valid_o (block_valid_o),
        .data_o      (block_o)
    );

endmodule

`default_nettype wire

/* include/tb_fetch_model.svh */
// Fetch reference model; include inside a module body, the model expects the DUT's redirects in order
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// BTB mirror, keyed by the full branch PC
bit                   mdl_valid  [fetch_cfg_pkg::BTB_ENTRIES];
fetch_cfg_pkg::addr_t mdl_pc     [fetch_cfg_pkg::BTB_ENTRIES];
fetch_cfg_pkg::addr_t mdl_target [fetch_cfg_pkg::BTB_ENTRIES];

function automatic void clear_btb_mirror();
    foreach (mdl_valid[i]) begin
        mdl_valid[i] = 1'b0;
    end
endfunction

function automatic int mirror_index(fetch_cfg_pkg::addr_t a);
    return int'(a[9:4]);
endfunction

function automatic fetch_msg_pkg::btb_pred_t lookup_btb_mirror(fetch_cfg_pkg::addr_t pc);
    fetch_msg_pkg::btb_pred_t p;
    int i;
    i = mirror_index(pc);
    p.hit    = mdl_valid[i] && mdl_pc[i][31:4] == pc[31:4] && mdl_pc[i][3:2] >= pc[3:2];
    p.slot   = mdl_pc[i][3:2];
    p.target = mdl_target[i];
    return p;
endfunction

function automatic fetch_cfg_pkg::mask_t enable_mask(fetch_cfg_pkg::addr_t pc,
                                                     fetch_msg_pkg::btb_pred_t p);
    fetch_cfg_pkg::mask_t m;
    for (int s = 0; s < 4; s++) begin
        m[s] = (s >= int'(pc[3:2])) && (!p.hit || s <= int'(p.slot));
    end
    return m;
endfunction

function automatic fetch_cfg_pkg::addr_t next_fetch_pc(fetch_cfg_pkg::addr_t pc,
                                                       fetch_msg_pkg::btb_pred_t p);
    return p.hit ? p.target : {pc[31:4] + 28'd1, 4'b0000};
endfunction

function automatic fetch_cfg_pkg::addr_t redirect_pc(fetch_msg_pkg::redirect_t r);
    if (r.exc_valid) begin
        return r.exc_pc;
    end
    return r.br_taken ? r.br_target : r.br_pc + 32'd4;
endfunction

function automatic void train_btb_mirror(fetch_msg_pkg::redirect_t r);
    int i;
    i = mirror_index(r.br_pc);
    if (r.br_valid && r.br_taken) begin
        mdl_valid[i]  = 1'b1;
        mdl_pc[i]     = r.br_pc;
        mdl_target[i] = r.br_target;
    end else if (r.br_valid && mdl_valid[i] && mdl_pc[i][31:2] == r.br_pc[31:2]) begin
        mdl_valid[i] = 1'b0;
    end
endfunction

// Cache contents: byte address of the word XOR a fixed pattern
function automatic logic [31:0] cache_word(fetch_cfg_pkg::addr_t a);
    return a ^ 32'h5A5A_0000;
endfunction

function automatic fetch_msg_pkg::fetch_block_t expected_block(fetch_cfg_pkg::addr_t pc);
    fetch_msg_pkg::fetch_block_t b;
    fetch_msg_pkg::btb_pred_t    p;
    p             = lookup_btb_mirror(pc);
    b.base_pc     = {pc[31:4], 4'b0000};
    b.mask        = enable_mask(pc, p);
    b.pred_taken  = p.hit;
    b.pred_target = p.target;
    for (int w = 0; w < 4; w++) begin
        b.data[w] = cache_word(b.base_pc + 32'(4 * w));
    end
    return b;
endfunction

`endif

/* sim/tb_fetch_stage.sv */
// Cache model answers in order, one block in flight; all inputs change on the falling clock edge
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_stage;
    import fetch_cfg_pkg::*;
    import fetch_msg_pkg::*;

    `include "tb_fetch_model.svh"

    logic         clk;
    logic         rst_n_i;
    logic         inst_req_o;
    addr_t        inst_index_o;
    logic         inst_index_ok_i;
    logic         inst_data_ok_i;
    block_data_t  inst_rdata_i;
    redirect_t    redirect_i;
    logic         stop_fetch_i;
    logic         block_valid_o;
    fetch_block_t block_o;

    addr_t        exp_pc;      // Model fetch PC
    int           blk_count;   // Blocks delivered so far
    fetch_block_t last_blk;

    fetch_stage_top dut (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_req_o      (inst_req_o),
        .inst_index_o    (inst_index_o),
        .inst_index_ok_i (inst_index_ok_i),
        .inst_data_ok_i  (inst_data_ok_i),
        .inst_rdata_i    (inst_rdata_i),
        .redirect_i      (redirect_i),
        .stop_fetch_i    (stop_fetch_i),
        .block_valid_o   (block_valid_o),
        .block_o         (block_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////
    task automatic report_failure(string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic expect_equal(string name, logic [255:0] exp_v, logic [255:0] got_v);
        assert (got_v === exp_v) else begin
            report_failure($sformatf("MISMATCH time=%0t signal=%s expected=%0h got=%0h",
                                     $time, name, exp_v, got_v));
        end
    endtask

    task automatic compare_block(fetch_block_t got);
        fetch_block_t exp_b;
        exp_b = expected_block(exp_pc);
        expect_equal("block_o.base_pc", 256'(exp_b.base_pc), 256'(got.base_pc));
        expect_equal("block_o.mask", 256'(exp_b.mask), 256'(got.mask));
        expect_equal("block_o.data", 256'(exp_b.data), 256'(got.data));
        expect_equal("block_o.pred_taken", 256'(exp_b.pred_taken), 256'(got.pred_taken));
        if (exp_b.pred_taken) begin
            expect_equal("block_o.pred_target", 256'(exp_b.pred_target),
                         256'(got.pred_target));
        end
        exp_pc    = next_fetch_pc(exp_pc, lookup_btb_mirror(exp_pc));
        last_blk  = got;
        blk_count = blk_count + 1;
    endtask

    task automatic expect_last(addr_t base, mask_t mask, logic taken);
        expect_equal("block_o.base_pc", 256'(base), 256'(last_blk.base_pc));
        expect_equal("block_o.mask", 256'(mask), 256'(last_blk.mask));
        expect_equal("block_o.pred_taken", 256'(taken), 256'(last_blk.pred_taken));
    endtask

    task automatic send_redirect(redirect_t r);
        redirect_i = r;
        @(negedge clk);
        redirect_i = '0;
    endtask

    task automatic wait_blocks(int n);
        int target;
        int cyc;
        target = blk_count + n;
        cyc    = 0;
        while (blk_count < target && cyc < 200) begin
            @(negedge clk);
            cyc++;
        end
        if (blk_count < target) begin
            report_failure($sformatf("timed out after %0d cycles waiting for a block", cyc));
        end
    endtask

    // Delivery or redirect at each rising edge
    always @(posedge clk) begin : compare_proc
        if (!rst_n_i) begin
            clear_btb_mirror();
            exp_pc    = RESET_PC;
            blk_count = 0;
        end else if (redirect_i.br_valid || redirect_i.exc_valid) begin
            train_btb_mirror(redirect_i);
            exp_pc = redirect_pc(redirect_i);
        end else if (block_valid_o && !stop_fetch_i) begin
            compare_block(block_o);
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction cache responder
    ////////////////////////////////////////////////////////////
    initial begin : cache_responder
        bit    busy;
        addr_t busy_addr;
        int    acc_wait;
        int    ret_wait;
        inst_index_ok_i = 1'b0;
        inst_data_ok_i  = 1'b0;
        inst_rdata_i    = '0;
        busy            = 1'b0;
        acc_wait        = 0;
        ret_wait        = 0;
        forever begin
            @(posedge clk);
            if (inst_req_o && inst_index_ok_i) begin
                busy      = 1'b1;
                busy_addr = inst_index_o;
                ret_wait  = $urandom_range(4, 1);   // Cycles until data_ok
            end
            @(negedge clk);
            inst_index_ok_i = 1'b0;
            inst_data_ok_i  = 1'b0;
            if (busy) begin
                ret_wait--;
                if (ret_wait == 0) begin
                    busy           = 1'b0;
                    inst_data_ok_i = 1'b1;
                    for (int w = 0; w < BLOCK_WORDS; w++) begin
                        inst_rdata_i[w] = cache_word(busy_addr + 32'(4 * w));
                    end
                end
            end else if (inst_req_o) begin
                if (acc_wait == 0) begin
                    inst_index_ok_i = 1'b1;
                    acc_wait        = $urandom_range(3, 0);
                end else begin
                    acc_wait--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        redirect_t r;
        void'($urandom(43));
        rst_n_i      = 1'b0;
        redirect_i   = '0;
        stop_fetch_i = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        expect_equal("inst_req_o", 256'(1'b0), 256'(inst_req_o));
        expect_equal("block_valid_o", 256'(1'b0), 256'(block_valid_o));

        // Sequential run from the boot vector
        wait_blocks(1);
        expect_last(RESET_PC, 4'b1111, 1'b0);
        wait_blocks(7);

        // Taken branch into slot 2 of a block
        r = '0;
        r.br_valid  = 1'b1;
        r.br_pc     = 32'h8000_0F00;
        r.br_taken  = 1'b1;
        r.br_target = 32'h8000_1008;
        send_redirect(r);
        wait_blocks(1);
        expect_last(32'h8000_1000, 4'b1100, 1'b0);
        wait_blocks(2);

        // Train a branch at slot 1 of block 8000_2000
        r = '0;
        r.br_valid  = 1'b1;
        r.br_pc     = 32'h8000_2004;
        r.br_taken  = 1'b1;
        r.br_target = 32'h8000_3040;
        send_redirect(r);
        wait_blocks(1);
        expect_last(32'h8000_3040, 4'b1111, 1'b0);
        r = '0;
        r.exc_valid = 1'b1;
        r.exc_pc    = 32'h8000_2000;
        send_redirect(r);
        wait_blocks(1);
        expect_last(32'h8000_2000, 4'b0011, 1'b1);
        expect_equal("block_o.pred_target", 256'(32'h8000_3040), 256'(last_blk.pred_target));
        wait_blocks(1);
        expect_last(32'h8000_3040, 4'b1111, 1'b0);
        wait_blocks(2);

        // Same branch resolves not taken
        r = '0;
        r.br_valid = 1'b1;
        r.br_pc    = 32'h8000_2004;
        send_redirect(r);
        wait_blocks(1);
        expect_last(32'h8000_2000, 4'b1100, 1'b0);
        r = '0;
        r.exc_valid = 1'b1;
        r.exc_pc    = 32'h8000_2000;
        send_redirect(r);
        wait_blocks(1);
        expect_last(32'h8000_2000, 4'b1111, 1'b0);
        wait_blocks(2);

        // Exception and branch in one cycle
        r = '0;
        r.exc_valid = 1'b1;
        r.exc_pc    = 32'h8000_4004;
        r.br_valid  = 1'b1;
        r.br_pc     = 32'h8000_5058;
        r.br_taken  = 1'b1;
        r.br_target = 32'h8000_6000;
        send_redirect(r);
        wait_blocks(1);
        expect_last(32'h8000_4000, 4'b1110, 1'b0);
        wait_blocks(2);

        // Random stop_fetch_i stretches, one redirect in the middle
        for (int k = 0; k < 40; k++) begin
            stop_fetch_i = ($urandom_range(1, 0) == 1);
            repeat ($urandom_range(6, 1)) @(negedge clk);
            if (k == 20) begin
                r = '0;
                r.exc_valid = 1'b1;
                r.exc_pc    = 32'h8000_7008;
                send_redirect(r);
            end
        end
        stop_fetch_i = 1'b0;
        wait_blocks(8);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_stage.f */
+incdir+include
design/fetch_cfg_pkg.sv
design/fetch_msg_pkg.sv
design/fetch_trace_stage.sv
design/pc_register.sv
design/branch_target_buffer.sv
design/fetch_stage_top.sv
sim/tb_fetch_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch_stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_stage.f \
    --top-module tb_fetch_stage \
    -o sim_fetch_stage

./obj_dir/sim_fetch_stage > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
